//--- compile.f
verilog/strobe_pkg.sv
verilog/strobe_timing_ctrl.sv
verilog/fr_slot_shifter.sv
verilog/fr_cycle_extender.sv
verilog/strobe_shaper_top.sv
testbench/tb_clock_gen.sv
testbench/strobe_shaper_assert.sv
testbench/strobe_shaper_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the strobe shaper testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
	-f compile.f \
	--top-module strobe_shaper_tb
./obj_dir/Vstrobe_shaper_tb | tee sim.log
if grep -q "all tests passed" sim.log
then
	echo "run_sim: simulation passed"
else
	echo "run_sim: simulation failed"
	exit 1
fi

//--- testbench/strobe_shaper_assert.sv
// bound into strobe_timing_ctrl; needs the simulator's assertion support switched on
`timescale 1ns/1ps

module strobe_shaper_assert
	import strobe_pkg::*;
#(
	parameter int data_width = 2
)
(
	input logic clk,
	input logic reset_n,
	input logic cfg_write,
	input logic stream_idle,
	input logic ext_idle,
	input logic [shift_width-1:0] shift,
	input logic [extend_width-1:0] extend_by,
	input logic [data_width-1:0] lane_mask,
	input logic cfg_pending
);

	// number of assertion failures so far
	int failures = 0;

	// nothing is waiting in the first cycle out of reset
	pending_low_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !cfg_pending)
		else
		begin
			$error("cfg_pending is set right after reset");
			failures++;
		end

	// a change of any active setting must follow a cycle where both blocks were idle
	settings_change_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
		(shift != $past(shift) || extend_by != $past(extend_by) || lane_mask != $past(lane_mask))
		|-> $past(stream_idle && ext_idle))
		else
		begin
			$error("active settings changed while a strobe was in flight");
			failures++;
		end

	// a write always shows up as a pending update one cycle later
	pending_after_write: assert property (@(posedge clk) disable iff (!reset_n)
		cfg_write |=> cfg_pending)
		else
		begin
			$error("cfg_pending did not rise after a config write");
			failures++;
		end

endmodule

//--- testbench/strobe_shaper_tb.sv
// runs DATA_WIDTH 2 with RESET_HIGH 0; config writes are issued only while cfg_pending is low
`timescale 1ns/1ps

module strobe_shaper_tb
	import strobe_pkg::*;
();

	localparam int data_width = 2;
	localparam int word_width = data_width * rate_mult;
	localparam int reset_cycles = 5;
	// idle cycles that one config update may need at most
	localparam int settle_budget = 8;
	localparam int write_cycles = 1 + settle_budget;
	localparam int pass_cycles = 40;
	localparam int ext_cycles = 3 * (write_cycles + 4 * rate_mult);
	localparam int shift_cycles = 8 * (write_cycles + 4);
	localparam int mask_cycles = 3 * write_cycles + 20;
	localparam int defer_cycles = 6 + settle_budget + 8;
	localparam int rand_cycles = 600;
	localparam int drain_cycles = 4;
	localparam int stim_cycles = reset_cycles + pass_cycles + ext_cycles + shift_cycles +
		mask_cycles + defer_cycles + rand_cycles + drain_cycles + 2;
	localparam int timeout_cycles = stim_cycles + 50;
	localparam int hist_depth = timeout_cycles + 4;

	logic clk;
	logic reset_n;
	logic [word_width-1:0] datain;
	logic cfg_write;
	logic cfg_addr;
	cfg_word_u cfg_data;
	logic [word_width-1:0] dataout;
	logic cfg_pending;

	int cycle_count = 0;
	int errors = 0;
	int checks = 0;

	// intended values behind the config word on the bus
	int req_shift;
	int req_ext;
	logic [data_width-1:0] req_mask;

	// the model's own staged and active settings
	int staged_shift;
	int staged_ext;
	logic [data_width-1:0] staged_mask;
	int model_shift;
	int model_ext;
	logic [data_width-1:0] model_mask;

	// per cycle: masked input word and the settings active in that cycle
	logic [word_width-1:0] f_hist [hist_depth];
	int shift_hist [hist_depth];
	int ext_hist [hist_depth];

	tb_clock_gen #(
		.reset_cycles(reset_cycles)
	) u_clock (
		.clk(clk),
		.reset_n(reset_n)
	);

	strobe_shaper_top #(
		.DATA_WIDTH(data_width),
		.RESET_HIGH(1'b0)
	) dut (
		.clk(clk),
		.reset_n(reset_n),
		.datain(datain),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.dataout(dataout),
		.cfg_pending(cfg_pending)
	);

	bind strobe_timing_ctrl strobe_shaper_assert #(
		.data_width(DATA_WIDTH)
	) u_ctrl_assert (
		.clk(clk),
		.reset_n(reset_n),
		.cfg_write(cfg_write),
		.stream_idle(stream_idle),
		.ext_idle(ext_idle),
		.shift(shift),
		.extend_by(extend_by),
		.lane_mask(lane_mask),
		.cfg_pending(cfg_pending)
	);

	// one set bit at the given slot and lane
	function automatic logic [word_width-1:0] slot_pulse(input int slot, input int lane);
		logic [word_width-1:0] w;
		w = '0;
		w[slot*data_width + lane] = 1'b1;
		return w;
	endfunction

	// output word of cycle c: each slot n entering the extender came from
	// masked stream slot n - rate_mult - shift, the shift being the one active
	// when that slot was selected, and output slot ORs slots n down to n - extend_by
	function automatic logic [word_width-1:0] expected_word(input int c);
		logic [word_width-1:0] w;
		int n;
		int src;
		int sel_cycle;
		w = '0;
		for (int k = 0; k < rate_mult; k++)
		begin
			for (int j = 0; j <= ext_hist[c]; j++)
			begin
				n = rate_mult * c + k - j;
				sel_cycle = n / rate_mult;
				// slots before time zero count as zero
				if (sel_cycle >= 1)
				begin
					src = n - rate_mult - shift_hist[sel_cycle-1];
					if (src >= 0)
					begin
						w[k*data_width +: data_width] |=
							f_hist[src/rate_mult][(src%rate_mult)*data_width +: data_width];
					end
				end
			end
		end
		return w;
	endfunction

	task automatic apply_inputs(input logic [word_width-1:0] word, input logic wr,
		input logic addr, input cfg_word_u data);
		@(posedge clk);
		#1;
		datain = word;
		cfg_write = wr;
		cfg_addr = addr;
		cfg_data = data;
	endtask

	task automatic send_word(input logic [word_width-1:0] word);
		apply_inputs(word, 1'b0, 1'b0, '0);
	endtask

	task automatic write_timing(input logic [shift_width-1:0] sh,
		input logic [extend_width-1:0] ex, input logic [word_width-1:0] word);
		cfg_word_u w;
		w = '0;
		w.timing.shift = sh;
		w.timing.extend_by = ex;
		req_shift = int'(sh);
		req_ext = int'(ex);
		apply_inputs(word, 1'b1, 1'b0, w);
	endtask

	task automatic mask_lanes(input logic [max_lanes-1:0] m, input logic [word_width-1:0] word);
		cfg_word_u w;
		w = '0;
		w.lanes.lane_mask = m;
		req_mask = m[data_width-1:0];
		apply_inputs(word, 1'b1, 1'b1, w);
	endtask

	// pending only shows one cycle after the write, so step once before polling
	task automatic wait_config_applied();
		send_word('0);
		while (cfg_pending)
		begin
			send_word('0);
		end
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	initial
	begin
		while (cycle_count < timeout_cycles)
		begin
			@(posedge clk);
		end
		$display("timeout: the run did not end within %0d cycles", timeout_cycles);
		$display("tests failed");
		$finish;
	end

	// model and compare, at the falling edge where inputs and outputs are stable
	initial
	begin
		logic pending_seen;
		logic [word_width-1:0] exp;
		int c;
		pending_seen = 1'b0;
		staged_shift = 0;
		staged_ext = 0;
		staged_mask = '1;
		model_shift = 0;
		model_ext = 0;
		model_mask = '1;
		// the stream before the first edge is the zero word driven at time zero
		f_hist[0] = '0;
		forever
		begin
			@(negedge clk);
			c = cycle_count;
			// the update took effect at the edge where pending fell
			if (pending_seen && !cfg_pending)
			begin
				model_shift = staged_shift;
				model_ext = staged_ext;
				model_mask = staged_mask;
			end
			pending_seen = cfg_pending;
			if (cfg_write)
			begin
				if (cfg_addr)
				begin
					staged_mask = req_mask;
				end
				else
				begin
					staged_shift = req_shift;
					staged_ext = req_ext;
				end
			end
			if (c < hist_depth)
			begin
				f_hist[c] = datain & {rate_mult{model_mask}};
				shift_hist[c] = model_shift;
				ext_hist[c] = model_ext;
				exp = expected_word(c);
				checks++;
				if (dataout !== exp)
				begin
					errors++;
					$display("MISMATCH at %0t: cycle %0d dataout %h, expected %h",
						$time, c, dataout, exp);
				end
			end
		end
	end

	initial
	begin
		logic [word_width-1:0] word;
		logic wrote_last;
		datain = '0;
		cfg_write = 1'b0;
		cfg_addr = 1'b0;
		cfg_data = '0;
		req_shift = 0;
		req_ext = 0;
		req_mask = '1;
		wrote_last = 1'b0;
		void'($urandom(39521));
		wait (reset_n);

		// pass-through with the reset settings
		for (int i = 0; i < pass_cycles; i++)
		begin
			send_word(word_width'($urandom));
		end

		// extension of single-slot pulses at every slot position
		for (int e = 1; e <= 3; e++)
		begin
			write_timing(3'd0, 2'(e), '0);
			wait_config_applied();
			for (int p = 0; p < rate_mult; p++)
			begin
				send_word(slot_pulse(p, 0));
				repeat (3) send_word('0);
			end
		end

		// every delay, with the pulse in the last slot so it crosses words
		for (int s = 0; s < 8; s++)
		begin
			write_timing(3'(s), 2'd0, '0);
			wait_config_applied();
			send_word(slot_pulse(3, 1));
			repeat (3) send_word('0);
		end

		// lane 1 switched off, then back on
		write_timing(3'd0, 2'd0, '0);
		wait_config_applied();
		mask_lanes(8'h01, '0);
		wait_config_applied();
		for (int i = 0; i < 20; i++)
		begin
			send_word(word_width'($urandom));
		end
		mask_lanes(8'hff, '0);
		wait_config_applied();

		// a write in the middle of a long strobe waits for the stream to drain
		for (int i = 0; i < 6; i++)
		begin
			if (i == 1)
			begin
				write_timing(3'd2, 2'd1, '1);
			end
			else
			begin
				send_word('1);
			end
			if (i >= 2 && !cfg_pending)
			begin
				errors++;
				$display("MISMATCH at %0t: cfg_pending low while a strobe is in flight", $time);
			end
		end
		send_word('0);
		if (!cfg_pending)
		begin
			errors++;
			$display("MISMATCH at %0t: cfg_pending low before the stream drained", $time);
		end
		while (cfg_pending)
		begin
			send_word('0);
		end
		send_word(slot_pulse(0, 0));
		repeat (3) send_word('0);
		send_word(slot_pulse(3, 1));
		repeat (3) send_word('0);

		// sparse random strobes with random config writes
		for (int i = 0; i < rand_cycles; i++)
		begin
			word = '0;
			if (($urandom % 4) == 0)
			begin
				word = word_width'($urandom) & word_width'($urandom);
			end
			// no write next to another one, so no write lands in an update cycle
			if (!cfg_pending && !wrote_last && ($urandom % 16) == 0)
			begin
				if (($urandom % 2) == 0)
				begin
					write_timing(3'($urandom), 2'($urandom), word);
				end
				else
				begin
					mask_lanes(8'($urandom), word);
				end
				wrote_last = 1'b1;
			end
			else
			begin
				send_word(word);
				wrote_last = 1'b0;
			end
		end

		repeat (drain_cycles) send_word('0);
		@(negedge clk);
		#1;
		errors = errors + dut.u_ctrl.u_ctrl_assert.failures;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- testbench/tb_clock_gen.sv
// free-running 10 ns clock; reset_n is released 1 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int reset_cycles = 5
)
(
	output logic clk,
	output logic reset_n
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset leaves with the same 1 ns offset that the stimulus uses
	initial
	begin
		reset_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset_n = 1'b1;
	end

endmodule

//--- verilog/fr_cycle_extender.sv
// combinational output from datain and one history word; a pulse widens by at most rate_mult-1 slots
`timescale 1ns/1ps

module fr_cycle_extender
	import strobe_pkg::*;
#(
	parameter int DATA_WIDTH = 2,
	parameter bit RESET_HIGH = 1'b0
)
(
	input  logic clk,
	input  logic reset_n,
	input  logic [extend_width-1:0] extend_by,
	input  logic [DATA_WIDTH*rate_mult-1:0] datain,
	output logic [DATA_WIDTH*rate_mult-1:0] dataout,
	output logic ext_idle
);

	localparam int word_width = DATA_WIDTH * rate_mult;

	// value the history takes while reset is asserted
	localparam logic [word_width-1:0] hist_reset = RESET_HIGH ? '1 : '0;

	// the word that came in one clk earlier
	logic [word_width-1:0] hist;

	// eight slots in time order, previous word in the low half
	logic [2*word_width-1:0] window;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			hist <= hist_reset;
		end
		else
		begin
			hist <= datain;
		end
	end

	assign window = {datain, hist};

	// each output slot k is the OR of slot k and the extend_by slots
	// before it, and for the early slots of the word those come from
	// the tail of the previous word
	always_comb
	begin
		dataout = '0;
		for (int k = 0; k < rate_mult; k++)
		begin
			for (int j = 0; j < rate_mult; j++)
			begin
				if (j <= int'(extend_by))
				begin
					dataout[k*DATA_WIDTH +: DATA_WIDTH] =
						dataout[k*DATA_WIDTH +: DATA_WIDTH] |
						window[(rate_mult+k-j)*DATA_WIDTH +: DATA_WIDTH];
				end
			end
		end
	end

	// only the history can stretch a pulse into a later word,
	// so an empty history means a new extension cannot cut a pulse
	assign ext_idle = ~|hist;

endmodule

//--- verilog/fr_slot_shifter.sv
// one clk of latency plus 0 to 7 slots of delay; lane_mask is applied at the input, before the history
`timescale 1ns/1ps

module fr_slot_shifter
	import strobe_pkg::*;
#(
	parameter int DATA_WIDTH = 2
)
(
	input  logic clk,
	input  logic reset_n,
	input  logic [DATA_WIDTH*rate_mult-1:0] datain,
	input  logic [DATA_WIDTH-1:0] lane_mask,
	input  logic [shift_width-1:0] shift,
	output logic [DATA_WIDTH*rate_mult-1:0] shifted,
	output logic stream_idle
);

	localparam int word_width = DATA_WIDTH * rate_mult;

	// current input word with the switched-off lanes cleared
	logic [word_width-1:0] masked;

	// masked words of the previous two cycles
	logic [word_width-1:0] hist_1;
	logic [word_width-1:0] hist_2;

	// twelve slots in time order, oldest in the least significant lanes
	logic [3*word_width-1:0] window;

	// index of the first selected slot inside the window
	logic [shift_width:0] base_slot;

	// the four slots that lie shift slots back from the current word
	logic [word_width-1:0] selected;

	// the same lane mask applies to every slot of the word
	genvar s;
	generate
		for (s = 0; s < rate_mult; s++)
		begin : mask_gen
			assign masked[s*DATA_WIDTH +: DATA_WIDTH] = datain[s*DATA_WIDTH +: DATA_WIDTH] & lane_mask;
		end
	endgenerate

	assign window = {masked, hist_1, hist_2};

	// the current word starts at slot 8 of the window
	// a delay of 7 reaches back to slot 1, which is still in hist_2
	assign base_slot = (shift_width + 1)'(2 * rate_mult) - {1'b0, shift};

	assign selected = window[base_slot*DATA_WIDTH +: word_width];

	// idle only when no set bit can still reach the output of this block
	// from the current word or from either history word
	assign stream_idle = ~|window;

	// history and output both start empty so the output is quiet after reset
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			hist_1 <= '0;
			hist_2 <= '0;
			shifted <= '0;
		end
		else
		begin
			hist_1 <= masked;
			hist_2 <= hist_1;
			shifted <= selected;
		end
	end

endmodule

//--- verilog/strobe_pkg.sv
// shared constants and config word layout; the lane mask field limits a design to max_lanes lanes
package strobe_pkg;

	// four full-rate slots travel in every clk word, slot 0 being the earliest
	localparam int rate_mult = 4;

	// slot delay setting, 0 to 7 full-rate slots
	localparam int shift_width = 3;

	// pulse extension setting, 0 to 3 further slots
	localparam int extend_width = 2;

	// upper bound on lanes per slot and width of the lane mask field
	localparam int max_lanes = 8;

	// timing view of the config word, read when cfg_addr is 0
	typedef struct packed {
		logic [max_lanes-shift_width-extend_width-1:0] spare;
		logic [extend_width-1:0] extend_by;
		logic [shift_width-1:0] shift;
	} cfg_timing_t;

	// lane view of the config word, read when cfg_addr is 1
	typedef struct packed {
		logic [max_lanes-1:0] lane_mask;
	} cfg_lanes_t;

	// one 8-bit config word, the address picks which view is decoded
	typedef union packed {
		cfg_timing_t timing;
		cfg_lanes_t lanes;
	} cfg_word_u;

endpackage

//--- verilog/strobe_shaper_top.sv
// DATA_WIDTH must not exceed max_lanes; no back-pressure, one word in and one word out per clk
`timescale 1ns/1ps

module strobe_shaper_top
	import strobe_pkg::*;
#(
	parameter int DATA_WIDTH = 2,
	parameter bit RESET_HIGH = 1'b0
)
(
	input  logic clk,
	input  logic reset_n,
	input  logic [DATA_WIDTH*rate_mult-1:0] datain,
	input  logic cfg_write,
	input  logic cfg_addr,
	input  cfg_word_u cfg_data,
	output logic [DATA_WIDTH*rate_mult-1:0] dataout,
	output logic cfg_pending
);

	// active settings from the control block
	logic [shift_width-1:0] shift;
	logic [extend_width-1:0] extend_by;
	logic [DATA_WIDTH-1:0] lane_mask;

	// masked and delayed stream between the two datapath stages
	logic [DATA_WIDTH*rate_mult-1:0] shifted;

	// idle flags back to the control block
	logic stream_idle;
	logic ext_idle;

	strobe_timing_ctrl #(
		.DATA_WIDTH(DATA_WIDTH)
	) u_ctrl (
		.clk(clk),
		.reset_n(reset_n),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.stream_idle(stream_idle),
		.ext_idle(ext_idle),
		.shift(shift),
		.extend_by(extend_by),
		.lane_mask(lane_mask),
		.cfg_pending(cfg_pending)
	);

	// masking and the registered slot delay come first
	fr_slot_shifter #(
		.DATA_WIDTH(DATA_WIDTH)
	) u_shifter (
		.clk(clk),
		.reset_n(reset_n),
		.datain(datain),
		.lane_mask(lane_mask),
		.shift(shift),
		.shifted(shifted),
		.stream_idle(stream_idle)
	);

	// the extender widens the delayed pulses without adding latency
	fr_cycle_extender #(
		.DATA_WIDTH(DATA_WIDTH),
		.RESET_HIGH(RESET_HIGH)
	) u_extender (
		.clk(clk),
		.reset_n(reset_n),
		.extend_by(extend_by),
		.datain(shifted),
		.dataout(dataout),
		.ext_idle(ext_idle)
	);

endmodule

//--- verilog/strobe_timing_ctrl.sv
// settings apply only when both idle flags are high, so a continuous strobe can hold an update back
`timescale 1ns/1ps

module strobe_timing_ctrl
	import strobe_pkg::*;
#(
	parameter int DATA_WIDTH = 2
)
(
	input  logic clk,
	input  logic reset_n,
	input  logic cfg_write,
	input  logic cfg_addr,
	input  cfg_word_u cfg_data,
	input  logic stream_idle,
	input  logic ext_idle,
	output logic [shift_width-1:0] shift,
	output logic [extend_width-1:0] extend_by,
	output logic [DATA_WIDTH-1:0] lane_mask,
	output logic cfg_pending
);

	// staged copies of every setting, written by the config strobe
	logic [shift_width-1:0] staged_shift;
	logic [extend_width-1:0] staged_extend;
	logic [DATA_WIDTH-1:0] staged_mask;

	// high in the one cycle where the staged values move to the active set
	logic apply;

	// an update waits until nothing is in flight in either datapath block
	// so a pulse never sees two different settings
	assign apply = cfg_pending & stream_idle & ext_idle;

	// staging registers start at the reset values of the active set
	// so that a write to one view leaves the other view as it is
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			staged_shift <= '0;
			staged_extend <= '0;
			staged_mask <= '1;
		end
		else if (cfg_write)
		begin
			// address 0 decodes the word through its timing view
			if (cfg_addr == 1'b0)
			begin
				staged_shift <= cfg_data.timing.shift;
				staged_extend <= cfg_data.timing.extend_by;
			end
			// address 1 decodes the same bits as a lane mask
			// and only the lanes that exist are kept
			else
			begin
				staged_mask <= cfg_data.lanes.lane_mask[DATA_WIDTH-1:0];
			end
		end
	end

	// the active settings feed the datapath from the cycle after apply
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			shift <= '0;
			extend_by <= '0;
			lane_mask <= '1;
		end
		else if (apply)
		begin
			shift <= staged_shift;
			extend_by <= staged_extend;
			lane_mask <= staged_mask;
		end
	end

	// pending rises the cycle after a write and falls with apply
	// a write in the same cycle as apply keeps it set, since the
	// newest staged value has not been transferred yet
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cfg_pending <= 1'b0;
		end
		else if (cfg_write)
		begin
			cfg_pending <= 1'b1;
		end
		else if (apply)
		begin
			cfg_pending <= 1'b0;
		end
	end

endmodule
